/* prng_pkg.sv */
package prng_pkg;

  // LFSR length and the reference feedback polynomial
  localparam int POLY_DEGREE = 16;
  localparam logic [POLY_DEGREE-1:0] DEF_POLY = 16'h6801;

  // Bus and RAM geometry
  localparam int DATA_W = 32;
  localparam int ADDR_W = 12;
  localparam int RAM_AW = 6;

  // Number of fill channels
  localparam int NUM_CH = 2;

  // One write into the pattern RAM
  typedef struct packed {
    logic [RAM_AW-1:0] addr;
    logic [DATA_W-1:0] data;
  } wr_req_t;

  // Channel setup as held in the register block
  typedef struct packed {
    logic [POLY_DEGREE-1:0] seed;
    logic [RAM_AW-1:0]      base;
    // One bit wider so a full 64 word fill fits
    logic [RAM_AW:0]        count;
  } ch_cfg_t;

  // Global registers
  localparam logic [ADDR_W-1:0] REG_CTRL   = 12'h000;
  localparam logic [ADDR_W-1:0] REG_STATUS = 12'h004;

  // Per channel block, channel n at REG_CH_BASE + n * CH_STRIDE
  localparam logic [ADDR_W-1:0] REG_CH_BASE = 12'h010;
  localparam int                CH_STRIDE   = 'h10;

  // Offsets inside a channel block
  localparam logic [ADDR_W-1:0] CH_SEED_OFS  = 12'h000;
  localparam logic [ADDR_W-1:0] CH_BASE_OFS  = 12'h004;
  localparam logic [ADDR_W-1:0] CH_COUNT_OFS = 12'h008;

  // RAM read window, word k at RAM_WIN + 4k
  localparam logic [ADDR_W-1:0] RAM_WIN = 12'h100;

endpackage

/* lfsr.sv */
`timescale 1ns/1ns

module lfsr #(
  parameter int                     POLY_DEGREE  = 16,
  parameter logic [POLY_DEGREE-1:0] POLYNOMIAL   = 16'h6801,
  parameter int                     OUTPUT_WIDTH = 32
) (
  input  logic                    i_clk,
  input  logic                    i_rst_n,

  input  logic                    i_init,
  input  logic [POLY_DEGREE-1:0]  i_seed,
  input  logic                    i_update,

  output logic [OUTPUT_WIDTH-1:0] o_out
);

  logic [POLY_DEGREE-1:0]  state_q;
  logic [POLY_DEGREE-1:0]  state_nxt;
  logic [OUTPUT_WIDTH-1:0] out_q;
  logic [OUTPUT_WIDTH-1:0] out_nxt;

  // Galois step, one output bit per iteration
  always_comb begin : step_blk
    logic                    bit_v;
    logic [POLY_DEGREE-1:0]  st_v;
    logic [OUTPUT_WIDTH-1:0] word_v;

    bit_v  = 1'b0;
    // Seed replaces the state before the first step
    st_v   = i_init ? i_seed : state_q;
    word_v = '0;
    for (int i = 0; i < OUTPUT_WIDTH; i++) begin
      bit_v = st_v[0];
      if (bit_v) begin
        st_v = st_v ^ POLYNOMIAL;
      end
      st_v   = {bit_v, st_v[POLY_DEGREE-1:1]};
      // First bit out ends up in the LSB after all shifts
      word_v = {bit_v, word_v[OUTPUT_WIDTH-1:1]};
    end
    state_nxt = st_v;
    out_nxt   = word_v;
  end

  always_ff @(posedge i_clk) begin : state_blk
    if (!i_rst_n) begin
      state_q <= '1;
      out_q   <= '0;
    end else if (i_update) begin
      state_q <= state_nxt;
      out_q   <= out_nxt;
    end
  end

  // Registered word, visible the cycle after update
  assign o_out = out_q;

endmodule

/* fill_engine.sv */
`timescale 1ns/1ns

module fill_engine import prng_pkg::*; #(
  parameter int                     POLY_DEGREE = prng_pkg::POLY_DEGREE,
  parameter logic [POLY_DEGREE-1:0] POLYNOMIAL  = prng_pkg::DEF_POLY,
  parameter int                     DATA_W      = prng_pkg::DATA_W,
  parameter int                     RAM_AW      = prng_pkg::RAM_AW
) (
  input  logic    i_clk,
  input  logic    i_rst_n,

  input  ch_cfg_t i_cfg,
  input  logic    i_start,
  output logic    o_busy,
  output logic    o_done,

  output wr_req_t o_req,
  output logic    o_req_valid,
  input  logic    i_grant
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SEED,
    ST_WRITE
  } state_t;

  state_t                 state_q;
  logic [RAM_AW-1:0]      addr_q;
  logic [RAM_AW:0]        left_q;
  logic [POLY_DEGREE-1:0] seed_q;
  logic                   valid_q;
  logic                   done_q;
  logic                   accept;
  logic                   lfsr_init;
  logic                   lfsr_update;
  logic [DATA_W-1:0]      word;

  assign accept      = valid_q & i_grant;
  assign lfsr_init   = (state_q == ST_SEED);
  // Seed and first step together, then one step per accepted write
  assign lfsr_update = lfsr_init | accept;

  lfsr #(
    .POLY_DEGREE  (POLY_DEGREE),
    .POLYNOMIAL   (POLYNOMIAL),
    .OUTPUT_WIDTH (DATA_W)
  ) lfsr_i (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_init   (lfsr_init),
    .i_seed   (seed_q),
    .i_update (lfsr_update),
    .o_out    (word)
  );

  always_ff @(posedge i_clk) begin : fsm_blk
    if (!i_rst_n) begin
      state_q <= ST_IDLE;
      addr_q  <= '0;
      left_q  <= '0;
      valid_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      case (state_q)
        // Start while busy never reaches this branch
        ST_IDLE: begin
          if (i_start) begin
            addr_q <= i_cfg.base;
            left_q <= i_cfg.count;
            done_q <= (i_cfg.count == '0);
            if (i_cfg.count != '0) begin
              state_q <= ST_SEED;
            end
          end
        end
        ST_SEED: begin
          state_q <= ST_WRITE;
          valid_q <= 1'b1;
        end
        ST_WRITE: begin
          if (accept) begin
            // Bubble cycle while the LFSR steps
            valid_q <= 1'b0;
            addr_q  <= addr_q + 1'b1;
            left_q  <= left_q - 1'b1;
            if (left_q == 1) begin
              state_q <= ST_IDLE;
              done_q  <= 1'b1;
            end
          end else begin
            valid_q <= 1'b1;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Seed captured at start
  always_ff @(posedge i_clk) begin : seed_blk
    if (state_q == ST_IDLE && i_start) begin
      seed_q <= i_cfg.seed;
    end
  end

  assign o_busy      = (state_q != ST_IDLE);
  assign o_done      = done_q;
  assign o_req.addr  = addr_q;
  assign o_req.data  = word;
  assign o_req_valid = valid_q;

endmodule

/* wr_arbiter.sv */
`timescale 1ns/1ns

module wr_arbiter #(
  parameter int  NUM_CH    = 2,
  parameter type payload_t = logic
) (
  input  logic              i_clk,
  input  logic              i_rst_n,

  input  payload_t          i_req [NUM_CH],
  input  logic [NUM_CH-1:0] i_valid,
  output logic [NUM_CH-1:0] o_grant,

  output payload_t          o_req,
  output logic              o_valid
);

  localparam int PTR_W = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;

  logic [PTR_W-1:0] ptr_q;
  logic [PTR_W-1:0] sel;
  logic             found;

  // Search starts at the pointer and wraps around
  always_comb begin : pick_blk
    int idx;

    idx     = 0;
    found   = 1'b0;
    sel     = '0;
    o_grant = '0;
    for (int i = 0; i < NUM_CH; i++) begin
      idx = (int'(ptr_q) + i) % NUM_CH;
      if (!found && i_valid[idx]) begin
        found = 1'b1;
        sel   = PTR_W'(idx);
      end
    end
    if (found) begin
      o_grant[sel] = 1'b1;
    end
  end

  // Channel after the winner gets first look next cycle
  always_ff @(posedge i_clk) begin : ptr_blk
    if (!i_rst_n) begin
      ptr_q <= '0;
    end else if (found) begin
      ptr_q <= (sel == PTR_W'(NUM_CH - 1)) ? '0 : sel + 1'b1;
    end
  end

  // Unregistered, the write lands on the accepting edge
  assign o_req   = i_req[sel];
  assign o_valid = found;

endmodule

/* pattern_ram.sv */
`timescale 1ns/1ns

module pattern_ram import prng_pkg::*; #(
  parameter int DATA_W = prng_pkg::DATA_W,
  parameter int RAM_AW = prng_pkg::RAM_AW
) (
  input  logic              i_clk,

  input  logic              i_wr_en,
  input  wr_req_t           i_wr,

  input  logic [RAM_AW-1:0] i_rd_addr,
  output logic [DATA_W-1:0] o_rd_data
);

  logic [DATA_W-1:0] mem [2**RAM_AW];

  always_ff @(posedge i_clk) begin : wr_blk
    if (i_wr_en) begin
      mem[i_wr.addr] <= i_wr.data;
    end
  end

  // One cycle read latency
  always_ff @(posedge i_clk) begin : rd_blk
    o_rd_data <= mem[i_rd_addr];
  end

endmodule

/* axil_regs.sv */
`timescale 1ns/1ns

module axil_regs import prng_pkg::*; #(
  parameter int NUM_CH      = prng_pkg::NUM_CH,
  parameter int POLY_DEGREE = prng_pkg::POLY_DEGREE,
  parameter int RAM_AW      = prng_pkg::RAM_AW
) (
  input  logic              i_clk,
  input  logic              i_rst_n,

  // AXI4-Lite write
  input  logic [ADDR_W-1:0] i_awaddr,
  input  logic              i_awvalid,
  output logic              o_awready,
  input  logic [DATA_W-1:0] i_wdata,
  input  logic              i_wvalid,
  output logic              o_wready,
  output logic              o_bvalid,
  input  logic              i_bready,
  output logic [1:0]        o_bresp,

  // AXI4-Lite read
  input  logic [ADDR_W-1:0] i_araddr,
  input  logic              i_arvalid,
  output logic              o_arready,
  output logic [DATA_W-1:0] o_rdata,
  output logic              o_rvalid,
  input  logic              i_rready,
  output logic [1:0]        o_rresp,

  // Channel control
  output ch_cfg_t           o_cfg [NUM_CH],
  output logic [NUM_CH-1:0] o_start,
  input  logic [NUM_CH-1:0] i_busy,
  input  logic [NUM_CH-1:0] i_done,

  // Pattern RAM read port
  output logic [RAM_AW-1:0] o_ram_addr,
  input  logic [DATA_W-1:0] i_ram_data
);

  // Low address bits that select a word inside the window
  localparam logic [ADDR_W-1:0] WIN_MASK = ADDR_W'((1 << (RAM_AW + 2)) - 1);

  logic              wr_fire;
  logic              ar_fire;
  logic              rd_pend_q;
  logic [ADDR_W-1:0] araddr_q;
  logic [DATA_W-1:0] rd_mux;

  function automatic logic [ADDR_W-1:0] ch_reg(input int ch, input logic [ADDR_W-1:0] ofs);
    return ADDR_W'(REG_CH_BASE + ch * CH_STRIDE) + ofs;
  endfunction

  // AW and W are taken together
  assign wr_fire   = i_awvalid & i_wvalid & ~o_bvalid;
  assign o_awready = wr_fire;
  assign o_wready  = wr_fire;
  assign o_bresp   = 2'b00;

  always_ff @(posedge i_clk) begin : wr_blk
    if (!i_rst_n) begin
      o_bvalid <= 1'b0;
      o_start  <= '0;
      for (int c = 0; c < NUM_CH; c++) begin
        o_cfg[c].seed  <= '1;
        o_cfg[c].base  <= '0;
        o_cfg[c].count <= '0;
      end
    end else begin
      // Start is a single cycle pulse
      o_start <= '0;
      if (o_bvalid && i_bready) begin
        o_bvalid <= 1'b0;
      end
      if (wr_fire) begin
        o_bvalid <= 1'b1;
        if (i_awaddr == REG_CTRL) begin
          o_start <= i_wdata[NUM_CH-1:0];
        end
        for (int c = 0; c < NUM_CH; c++) begin
          if (i_awaddr == ch_reg(c, CH_SEED_OFS)) begin
            o_cfg[c].seed <= i_wdata[POLY_DEGREE-1:0];
          end
          if (i_awaddr == ch_reg(c, CH_BASE_OFS)) begin
            o_cfg[c].base <= i_wdata[RAM_AW-1:0];
          end
          if (i_awaddr == ch_reg(c, CH_COUNT_OFS)) begin
            o_cfg[c].count <= i_wdata[RAM_AW:0];
          end
        end
      end
    end
  end

  // One read in flight at a time
  assign o_arready = i_arvalid & ~rd_pend_q & ~o_rvalid;
  assign ar_fire   = i_arvalid & o_arready;
  assign o_rresp   = 2'b00;
  // RAM sees the AR address directly, data is back next cycle
  assign o_ram_addr = i_araddr[RAM_AW+1:2];

  always_comb begin : rd_mux_blk
    rd_mux = '0;
    if ((araddr_q & ~WIN_MASK) == RAM_WIN) begin
      rd_mux = i_ram_data;
    end else if (araddr_q == REG_STATUS) begin
      rd_mux = DATA_W'({i_done, i_busy});
    end
    for (int c = 0; c < NUM_CH; c++) begin
      if (araddr_q == ch_reg(c, CH_SEED_OFS)) begin
        rd_mux = DATA_W'(o_cfg[c].seed);
      end
      if (araddr_q == ch_reg(c, CH_BASE_OFS)) begin
        rd_mux = DATA_W'(o_cfg[c].base);
      end
      if (araddr_q == ch_reg(c, CH_COUNT_OFS)) begin
        rd_mux = DATA_W'(o_cfg[c].count);
      end
    end
  end

  always_ff @(posedge i_clk) begin : rd_ctrl_blk
    if (!i_rst_n) begin
      rd_pend_q <= 1'b0;
      o_rvalid  <= 1'b0;
    end else begin
      rd_pend_q <= ar_fire;
      if (rd_pend_q) begin
        o_rvalid <= 1'b1;
      end else if (o_rvalid && i_rready) begin
        o_rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin : rd_data_blk
    if (ar_fire) begin
      araddr_q <= i_araddr;
    end
    if (rd_pend_q) begin
      o_rdata <= rd_mux;
    end
  end

endmodule

/* prng_fill_top.sv */
`timescale 1ns/1ns

module prng_fill_top import prng_pkg::*; #(
  parameter int                     POLY_DEGREE = prng_pkg::POLY_DEGREE,
  parameter logic [POLY_DEGREE-1:0] POLYNOMIAL  = DEF_POLY,
  parameter int                     DATA_W      = prng_pkg::DATA_W,
  parameter int                     RAM_AW      = prng_pkg::RAM_AW,
  parameter int                     NUM_CH      = prng_pkg::NUM_CH
) (
  input  logic              i_clk,
  input  logic              i_rst_n,

  input  logic [ADDR_W-1:0] i_awaddr,
  input  logic              i_awvalid,
  output logic              o_awready,
  input  logic [DATA_W-1:0] i_wdata,
  input  logic              i_wvalid,
  output logic              o_wready,
  output logic              o_bvalid,
  input  logic              i_bready,
  output logic [1:0]        o_bresp,
  input  logic [ADDR_W-1:0] i_araddr,
  input  logic              i_arvalid,
  output logic              o_arready,
  output logic [DATA_W-1:0] o_rdata,
  output logic              o_rvalid,
  input  logic              i_rready,
  output logic [1:0]        o_rresp
);

  ch_cfg_t           cfg [NUM_CH];
  logic [NUM_CH-1:0] start;
  logic [NUM_CH-1:0] busy;
  logic [NUM_CH-1:0] done;
  wr_req_t           req [NUM_CH];
  logic [NUM_CH-1:0] req_valid;
  logic [NUM_CH-1:0] grant;
  wr_req_t           ram_wr;
  logic              ram_wr_en;
  logic [RAM_AW-1:0] ram_rd_addr;
  logic [DATA_W-1:0] ram_rd_data;

  axil_regs #(
    .NUM_CH      (NUM_CH),
    .POLY_DEGREE (POLY_DEGREE),
    .RAM_AW      (RAM_AW)
  ) regs_i (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_awaddr   (i_awaddr),
    .i_awvalid  (i_awvalid),
    .o_awready  (o_awready),
    .i_wdata    (i_wdata),
    .i_wvalid   (i_wvalid),
    .o_wready   (o_wready),
    .o_bvalid   (o_bvalid),
    .i_bready   (i_bready),
    .o_bresp    (o_bresp),
    .i_araddr   (i_araddr),
    .i_arvalid  (i_arvalid),
    .o_arready  (o_arready),
    .o_rdata    (o_rdata),
    .o_rvalid   (o_rvalid),
    .i_rready   (i_rready),
    .o_rresp    (o_rresp),
    .o_cfg      (cfg),
    .o_start    (start),
    .i_busy     (busy),
    .i_done     (done),
    .o_ram_addr (ram_rd_addr),
    .i_ram_data (ram_rd_data)
  );

  // One LFSR fill engine per channel
  for (genvar g = 0; g < NUM_CH; g++) begin : g_ch
    fill_engine #(
      .POLY_DEGREE (POLY_DEGREE),
      .POLYNOMIAL  (POLYNOMIAL),
      .DATA_W      (DATA_W),
      .RAM_AW      (RAM_AW)
    ) fill_i (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_cfg       (cfg[g]),
      .i_start     (start[g]),
      .o_busy      (busy[g]),
      .o_done      (done[g]),
      .o_req       (req[g]),
      .o_req_valid (req_valid[g]),
      .i_grant     (grant[g])
    );
  end

  wr_arbiter #(
    .NUM_CH    (NUM_CH),
    .payload_t (wr_req_t)
  ) arb_i (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_req   (req),
    .i_valid (req_valid),
    .o_grant (grant),
    .o_req   (ram_wr),
    .o_valid (ram_wr_en)
  );

  pattern_ram #(
    .DATA_W (DATA_W),
    .RAM_AW (RAM_AW)
  ) ram_i (
    .i_clk     (i_clk),
    .i_wr_en   (ram_wr_en),
    .i_wr      (ram_wr),
    .i_rd_addr (ram_rd_addr),
    .o_rd_data (ram_rd_data)
  );

endmodule

/* tb_prng_fill.sv */
`timescale 1ns/1ns

module tb_prng_fill import prng_pkg::*; ();

  localparam int TIMEOUT   = 2000;
  localparam int STALL_MAX = 4;
  localparam int ST_W      = 2 * NUM_CH;

  logic              clk;
  logic              rst_n;
  logic [ADDR_W-1:0] awaddr;
  logic              awvalid;
  logic              awready;
  logic [DATA_W-1:0] wdata;
  logic              wvalid;
  logic              wready;
  logic              bvalid;
  logic              bready;
  logic [1:0]        bresp;
  logic [ADDR_W-1:0] araddr;
  logic              arvalid;
  logic              arready;
  logic [DATA_W-1:0] rdata;
  logic              rvalid;
  logic              rready;
  logic [1:0]        rresp;

  int unsigned       cycle_cnt;
  // Register shadow and the config each channel was started with
  ch_cfg_t           sh_cfg [NUM_CH];
  ch_cfg_t           run_cfg [NUM_CH];
  logic [NUM_CH-1:0] running;

  prng_fill_top #(
    .POLY_DEGREE (POLY_DEGREE),
    .POLYNOMIAL  (DEF_POLY),
    .DATA_W      (DATA_W),
    .RAM_AW      (RAM_AW),
    .NUM_CH      (NUM_CH)
  ) dut_i (
    .i_clk     (clk),
    .i_rst_n   (rst_n),
    .i_awaddr  (awaddr),
    .i_awvalid (awvalid),
    .o_awready (awready),
    .i_wdata   (wdata),
    .i_wvalid  (wvalid),
    .o_wready  (wready),
    .o_bvalid  (bvalid),
    .i_bready  (bready),
    .o_bresp   (bresp),
    .i_araddr  (araddr),
    .i_arvalid (arvalid),
    .o_arready (arready),
    .o_rdata   (rdata),
    .o_rvalid  (rvalid),
    .i_rready  (rready),
    .o_rresp   (rresp)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("mismatch at %0t ns: %s got 0x%08h expected 0x%08h",
                              $time, name, got, exp));
    end
  endtask

  task automatic check_status(input logic [ST_W-1:0] got, input logic [ST_W-1:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("mismatch at %0t ns: status got 0x%0h expected 0x%0h",
                              $time, got, exp));
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] got,
                            input logic [1:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("mismatch at %0t ns: %s got %0d expected %0d",
                              $time, name, got, exp));
    end
  endtask

  function automatic logic [ADDR_W-1:0] reg_addr(input int ch, input logic [ADDR_W-1:0] ofs);
    return ADDR_W'(REG_CH_BASE + ch * CH_STRIDE) + ofs;
  endfunction

  // One Galois step per output bit, first bit lands in the word LSB
  task automatic next_model_word(inout logic [POLY_DEGREE-1:0] st,
                                 output logic [DATA_W-1:0] word);
    logic b;

    word = '0;
    for (int i = 0; i < DATA_W; i++) begin
      b = st[0];
      if (b) begin
        st = st ^ DEF_POLY;
      end
      st   = {b, st[POLY_DEGREE-1:1]};
      word = {b, word[DATA_W-1:1]};
    end
  endtask

  // Track config writes and starts the way the register map defines them
  task automatic note_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    for (int c = 0; c < NUM_CH; c++) begin
      if (addr == REG_CTRL && data[c] && !running[c]) begin
        run_cfg[c] = sh_cfg[c];
        running[c] = 1'b1;
      end
      if (addr == reg_addr(c, CH_SEED_OFS)) begin
        sh_cfg[c].seed = data[POLY_DEGREE-1:0];
      end
      if (addr == reg_addr(c, CH_BASE_OFS)) begin
        sh_cfg[c].base = data[RAM_AW-1:0];
      end
      if (addr == reg_addr(c, CH_COUNT_OFS)) begin
        sh_cfg[c].count = data[RAM_AW:0];
      end
    end
  endtask

  task automatic axi_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    int waited;
    int stall;

    @(posedge clk);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wvalid  <= 1'b1;
    waited = 0;
    @(negedge clk);
    while (!(awready && wready)) begin
      waited++;
      if (waited > TIMEOUT) stop_on_error("write address and data were never accepted");
      @(negedge clk);
    end
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    stall = int'($urandom % (STALL_MAX + 1));
    repeat (stall) @(posedge clk);
    bready <= 1'b1;
    waited = 0;
    @(negedge clk);
    while (!bvalid) begin
      waited++;
      if (waited > TIMEOUT) stop_on_error("write response never arrived");
      @(negedge clk);
    end
    check_resp("bresp", bresp, 2'b00);
    @(posedge clk);
    bready <= 1'b0;
    note_write(addr, data);
  endtask

  task automatic axi_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
    int waited;
    int stall;

    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    waited = 0;
    @(negedge clk);
    while (!arready) begin
      waited++;
      if (waited > TIMEOUT) stop_on_error("read address was never accepted");
      @(negedge clk);
    end
    @(posedge clk);
    arvalid <= 1'b0;
    stall = int'($urandom % (STALL_MAX + 1));
    repeat (stall) @(posedge clk);
    rready <= 1'b1;
    waited = 0;
    @(negedge clk);
    while (!rvalid) begin
      waited++;
      if (waited > TIMEOUT) stop_on_error("read data never arrived");
      @(negedge clk);
    end
    data = rdata;
    check_resp("rresp", rresp, 2'b00);
    @(posedge clk);
    rready <= 1'b0;
  endtask

  // Poll for done, then read the channel's range back through the window
  task automatic check_fill(input int ch);
    logic [DATA_W-1:0]      rd;
    logic [DATA_W-1:0]      exp;
    logic [POLY_DEGREE-1:0] st;
    logic [RAM_AW-1:0]      addr;
    int unsigned            start;

    if (!running[ch]) stop_on_error($sformatf("channel %0d checked but never started", ch));
    start = cycle_cnt;
    axi_read(REG_STATUS, rd);
    while (!rd[NUM_CH+ch]) begin
      if (cycle_cnt - start > TIMEOUT) begin
        stop_on_error($sformatf("channel %0d never reported done", ch));
      end
      axi_read(REG_STATUS, rd);
    end
    if (rd[ch]) stop_on_error($sformatf("channel %0d still busy with done set", ch));
    st   = run_cfg[ch].seed;
    addr = run_cfg[ch].base;
    for (int k = 0; k < int'(run_cfg[ch].count); k++) begin
      next_model_word(st, exp);
      axi_read(RAM_WIN + ADDR_W'({addr, 2'b00}), rd);
      check_word($sformatf("ram[%0d]", addr), rd, exp);
      // Wraps modulo the RAM depth
      addr = addr + 1'b1;
    end
    running[ch] = 1'b0;
  endtask

  initial begin
    int                fd;
    int                code;
    byte               op;
    logic [31:0]       a1;
    logic [31:0]       a2;
    string             line;
    logic [DATA_W-1:0] rd;

    void'($urandom(32'h6890));
    rst_n     = 1'b0;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wvalid    = 1'b0;
    bready    = 1'b0;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    cycle_cnt = 0;
    running   = '0;
    for (int c = 0; c < NUM_CH; c++) begin
      sh_cfg[c].seed  = '1;
      sh_cfg[c].base  = '0;
      sh_cfg[c].count = '0;
      run_cfg[c]      = sh_cfg[c];
    end

    fd = $fopen("tb_input.txt", "r");
    if (fd == 0) stop_on_error("cannot open tb_input.txt");
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    while (1) begin
      code = $fscanf(fd, " %c", op);
      if (code != 1) break;
      case (op)
        "#": code = $fgets(line, fd);
        "W": begin
          code = $fscanf(fd, "%h %h", a1, a2);
          if (code != 2) stop_on_error("malformed write line in tb_input.txt");
          axi_write(a1[ADDR_W-1:0], a2);
        end
        "R": begin
          code = $fscanf(fd, "%h %h", a1, a2);
          if (code != 2) stop_on_error("malformed read line in tb_input.txt");
          axi_read(a1[ADDR_W-1:0], rd);
          if (a1[ADDR_W-1:0] == REG_STATUS) begin
            check_status(rd[ST_W-1:0], a2[ST_W-1:0]);
          end else begin
            check_word($sformatf("reg 0x%03h", a1[ADDR_W-1:0]), rd, a2);
          end
        end
        "F": begin
          code = $fscanf(fd, "%h", a1);
          if (code != 1 || a1 >= NUM_CH) stop_on_error("malformed fill line in tb_input.txt");
          check_fill(int'(a1));
        end
        default: stop_on_error($sformatf("unknown command %c in tb_input.txt", op));
      endcase
    end
    $fclose(fd);

    $display("** PASS **");
    $finish;
  end

endmodule

/* tb_input.txt */
# Columns: W addr data | R addr expected | F channel (all values hex)
# F waits for done, then checks the channel's RAM words against the LFSR model
# Reset values, including an unmapped address
R 004 00000000
R 010 0000ffff
R 014 00000000
R 018 00000000
R 020 0000ffff
R 024 00000000
R 028 00000000
R 00c 00000000
# Channel setup reads back
W 010 0000ace1
W 014 00000000
W 018 00000010
W 020 00001d2b
W 024 0000003c
W 028 0000000a
R 010 0000ace1
R 014 00000000
R 018 00000010
R 020 00001d2b
R 024 0000003c
R 028 0000000a
# Single channel fill
W 000 00000001
F 0
R 004 00000004
# Both channels at once, channel 1 wraps past the top
W 014 00000020
W 000 00000003
F 0
F 1
R 004 0000000c
# Start while busy is ignored
W 010 0000beef
W 014 00000010
W 018 00000028
W 000 00000001
W 010 00001234
W 000 00000001
R 004 00000009
R 010 00001234
F 0
R 004 0000000c

/* files.f */
prng_pkg.sv
lfsr.sv
fill_engine.sv
wr_arbiter.sv
pattern_ram.sv
axil_regs.sv
prng_fill_top.sv
tb_prng_fill.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing
TOP       := tb_prng_fill
FILELIST  := files.f
DATA      := tb_input.txt
LOG       := sim.log

SRCS := $(shell cat $(FILELIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN) $(DATA)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qF '** PASS **' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
